// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define DATA_W      16
`define PC_W        16
`define REG_ADDR_W  3

// register file and instruction buffer sizes
`define REG_COUNT   8
`define QUEUE_DEPTH 4

// first fetch address out of reset
`define RESET_PC    16'h0000

`endif

// ==== design/exec_unit.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module exec_unit (
    input  logic                    clk_50MHz,
    input  logic                    rst,
    input  logic                    hold_i,
    inst_stream_if.dst              in_i,
    output logic                    flush_o,
    output logic [`PC_W-1:0]        target_o,
    output logic                    wb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wb_addr_o,
    output logic [`DATA_W-1:0]      wb_data_o
);

    isa_pkg::inst_u iw;

    logic [`DATA_W-1:0]     regs [`REG_COUNT];
    logic [`DATA_W-1:0]     rx_val;
    logic [`DATA_W-1:0]     ry_val;
    logic [`DATA_W-1:0]     imm_zext;
    logic [`DATA_W-1:0]     imm_sext;
    logic                   accept;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`DATA_W-1:0]     wr_data;
    logic                   taken;

    assign iw = in_i.inst;

    assign in_i.ready = !hold_i;
    assign accept     = in_i.valid && in_i.ready;

    // operand fetch, rx from the immediate view and ry from the register view
    assign rx_val   = regs[iw.i_fmt.rx];
    assign ry_val   = regs[iw.r_fmt.ry];
    assign imm_zext = {8'h00, iw.i_fmt.imm};
    assign imm_sext = {{8{iw.i_fmt.imm[7]}}, iw.i_fmt.imm};

    // ************************************************
    // decode and adder
    // ************************************************

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = iw.i_fmt.rx;
        wr_data = rx_val + imm_sext;
        taken   = 1'b0;
        case (iw.i_fmt.opcode)
            opcode_pkg::OP_LI: begin
                wr_en   = 1'b1;
                wr_data = imm_zext;
            end
            opcode_pkg::OP_ADDIU: begin
                wr_en = 1'b1;
            end
            opcode_pkg::OP_RR: begin
                wr_addr = iw.r_fmt.rz;
                if (iw.r_fmt.funct == opcode_pkg::FN_ADDU) begin
                    wr_en   = 1'b1;
                    wr_data = rx_val + ry_val;
                end else if (iw.r_fmt.funct == opcode_pkg::FN_SUBU) begin
                    wr_en   = 1'b1;
                    wr_data = rx_val - ry_val;
                end
            end
            opcode_pkg::OP_BEQZ: begin
                taken = (rx_val == '0);
            end
            // NOP and unknown opcodes fall here
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    // branch target is relative to the next instruction
    assign target_o = in_i.pc + `PC_W'(1) + imm_sext;
    assign flush_o  = accept && taken;

    // ************************************************
    // register file and writeback
    // ************************************************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (accept && wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= accept && wr_en;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (accept && wr_en) begin
            wb_addr_o <= wr_addr;
            wb_data_o <= wr_data;
        end
    end

endmodule

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module fetch_queue (
    input  logic        clk_50MHz,
    input  logic        rst,
    input  logic        flush_i,
    inst_stream_if.dst  in_i,
    inst_stream_if.src  out_o
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`QUEUE_DEPTH);

    logic [`PC_W-1:0]   pc_mem   [`QUEUE_DEPTH];
    logic [`DATA_W-1:0] inst_mem [`QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_i.ready  = (count != FULL_CNT);
    assign out_o.valid = (count != '0);
    assign out_o.pc    = pc_mem[rd_ptr];
    assign out_o.inst  = inst_mem[rd_ptr];

    // nothing moves in the flush cycle
    assign push = in_i.valid && in_i.ready && !flush_i;
    assign pop  = out_o.valid && out_o.ready && !flush_i;

    // ************************************************
    // pointers and occupancy
    // ************************************************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // entry storage
    always_ff @(posedge clk_50MHz) begin
        if (push) begin
            pc_mem[wr_ptr]   <= in_i.pc;
            inst_mem[wr_ptr] <= in_i.inst;
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module fetch_unit (
    input  logic                clk_50MHz,
    input  logic                rst,
    output logic [`PC_W-1:0]    imem_addr_o,
    input  logic [`DATA_W-1:0]  imem_data_i,
    input  logic                flush_i,
    input  logic [`PC_W-1:0]    target_i,
    inst_stream_if.src          stream_o
);

    logic [`PC_W-1:0] pc_q;
    logic             take;

    // memory always answers, so a fetch is on offer every cycle
    assign stream_o.valid = 1'b1;
    assign stream_o.pc    = pc_q;
    assign stream_o.inst  = imem_data_i;

    assign imem_addr_o = pc_q;

    assign take = stream_o.valid && stream_o.ready;

    // ************************************************
    // program counter
    // ************************************************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc_q <= `RESET_PC;
        end else if (flush_i) begin
            // redirect wins, the word fetched this cycle is wrong path
            pc_q <= target_i;
        end else if (take) begin
            pc_q <= pc_q + `PC_W'(1);
        end
    end

endmodule

// ==== design/inst_stream_if.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

interface inst_stream_if;

    logic                valid;
    logic                ready;
    logic [`PC_W-1:0]    pc;
    logic [`DATA_W-1:0]  inst;

    // producer side holds pc and inst while valid and not ready
    modport src (output valid, output pc, output inst, input ready);

    modport dst (input valid, input pc, input inst, output ready);

endinterface

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // ************************************************
    // instruction word formats
    // ************************************************

    // three-register form, used by ADDU and SUBU
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rx;
        logic [2:0] ry;
        logic [2:0] rz;
        logic [1:0] funct;
    } rr_fmt_t;

    // register plus 8-bit immediate, used by LI, ADDIU and BEQZ
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rx;
        logic [7:0] imm;
    } imm_fmt_t;

    // same 16 bits seen through either format
    typedef union packed {
        rr_fmt_t  r_fmt;
        imm_fmt_t i_fmt;
    } inst_u;

endpackage

// ==== design/opcode_pkg.sv ====
package opcode_pkg;

    // ************************************************
    // major opcodes, bits 15:11
    // ************************************************

    localparam logic [4:0] OP_LI    = 5'b01101;
    localparam logic [4:0] OP_ADDIU = 5'b01001;
    localparam logic [4:0] OP_BEQZ  = 5'b00100;
    localparam logic [4:0] OP_NOP   = 5'b00001;

    // ADDU and SUBU share this opcode
    localparam logic [4:0] OP_RR    = 5'b11100;

    // ************************************************
    // function field of the OP_RR group, bits 1:0
    // ************************************************

    localparam logic [1:0] FN_ADDU  = 2'b01;
    localparam logic [1:0] FN_SUBU  = 2'b11;

endpackage

// ==== design/tiny_cpu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module tiny_cpu (
    input  logic                    clk_50MHz,
    input  logic                    rst,
    input  logic                    hold_i,
    input  logic [`DATA_W-1:0]      imem_data_i,
    output logic [`PC_W-1:0]        imem_addr_o,
    output logic                    wb_valid_o,
    output logic [`REG_ADDR_W-1:0]  wb_addr_o,
    output logic [`DATA_W-1:0]      wb_data_o
);

    logic             flush;
    logic [`PC_W-1:0] target;

    // fetch to buffer, buffer to execute
    inst_stream_if fetch_s ();
    inst_stream_if exec_s ();

    fetch_unit u_fetch (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .flush_i     (flush),
        .target_i    (target),
        .stream_o    (fetch_s)
    );

    fetch_queue u_queue (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .flush_i   (flush),
        .in_i      (fetch_s),
        .out_o     (exec_s)
    );

    exec_unit u_exec (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .hold_i     (hold_i),
        .in_i       (exec_s),
        .flush_o    (flush),
        .target_o   (target),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_tiny_cpu with Verilator, verdict taken from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_tiny_cpu -f vlog.f -o sim_tiny_cpu > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tiny_cpu +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "simulator exited with a nonzero status"
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation PASSED"

// ==== tb/cpu_assertions.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_assertions (
    input logic              clk_50MHz,
    input logic              rst,
    input logic              hold_i,
    input logic              flush,
    input logic [`PC_W-1:0]  imem_addr_o,
    input logic              wb_valid_o
);

    int         fail_count = 0;
    logic [2:0] hold_run;

    // consecutive cycles with hold high, saturating at 7
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            hold_run <= '0;
        end else if (!hold_i) begin
            hold_run <= '0;
        end else if (hold_run != 3'd7) begin
            hold_run <= hold_run + 3'd1;
        end
    end

    // ************************************************
    // reset, hold and redirect rules
    // ************************************************

    reset_idle: assert property (@(posedge clk_50MHz)
        !rst |-> (!wb_valid_o && imem_addr_o == `RESET_PC))
        else begin
            $error("outputs not idle while reset is asserted");
            fail_count++;
        end

    hold_blocks_wb: assert property (@(posedge clk_50MHz) disable iff (!rst)
        hold_i |=> !wb_valid_o)
        else begin
            $error("writeback seen in the cycle after hold was high");
            fail_count++;
        end

    // queue is full by now, so fetch must have stalled
    addr_frozen: assert property (@(posedge clk_50MHz) disable iff (!rst)
        (hold_i && hold_run >= 3'd6) |-> $stable(imem_addr_o))
        else begin
            $error("fetch address moved during a long hold");
            fail_count++;
        end

    // buffer is empty in the cycle after a redirect
    taken_no_wb: assert property (@(posedge clk_50MHz) disable iff (!rst)
        $past(flush) |=> !wb_valid_o)
        else begin
            $error("wrong-path instruction retired after a taken branch");
            fail_count++;
        end

endmodule

bind tiny_cpu cpu_assertions u_asrt (
    .clk_50MHz   (clk_50MHz),
    .rst         (rst),
    .hold_i      (hold_i),
    .flush       (flush),
    .imem_addr_o (imem_addr_o),
    .wb_valid_o  (wb_valid_o)
);

// ==== tb/tb_tiny_cpu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module tb_tiny_cpu;

    localparam int RUN_LIMIT = 300;

    logic                   clk_50MHz;
    logic                   rst;
    logic                   hold_i;
    logic [`DATA_W-1:0]     imem_data_i;
    logic [`PC_W-1:0]       imem_addr_o;
    logic                   wb_valid_o;
    logic [`REG_ADDR_W-1:0] wb_addr_o;
    logic [`DATA_W-1:0]     wb_data_o;

    logic [`DATA_W-1:0]     imem [64];
    logic [`REG_ADDR_W-1:0] exp_addr [$];
    logic [`DATA_W-1:0]     exp_data [$];
    int                     errors;
    int                     tests_passed;
    int                     tests_failed;

    tiny_cpu i_dut (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .hold_i      (hold_i),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .wb_valid_o  (wb_valid_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // instruction memory answers in the same cycle
    assign imem_data_i = imem[imem_addr_o[5:0]];

    function automatic logic [`DATA_W-1:0] imm_word(input logic [4:0] op,
            input logic [2:0] rx, input logic [7:0] imm);
        return {op, rx, imm};
    endfunction

    function automatic logic [`DATA_W-1:0] rr_word(input logic [2:0] rx,
            input logic [2:0] ry, input logic [2:0] rz, input logic [1:0] fn);
        return {opcode_pkg::OP_RR, rx, ry, rz, fn};
    endfunction

    function automatic int fault_total();
        return errors + i_dut.u_asrt.fail_count;
    endfunction

    // unused words are NOPs tagged with their own address
    task automatic load_program(input int prog);
        for (int a = 0; a < 64; a++) begin
            imem[a] = {opcode_pkg::OP_NOP, 11'(a)};
        end
        if (prog == 0) begin
            imem[0] = imm_word(opcode_pkg::OP_LI, 3'd1, 8'h05);
            imem[1] = imm_word(opcode_pkg::OP_ADDIU, 3'd1, 8'hfe);
            imem[2] = imm_word(opcode_pkg::OP_LI, 3'd2, 8'h80);
            imem[3] = imm_word(opcode_pkg::OP_ADDIU, 3'd2, 8'h7f);
            imem[4] = imm_word(opcode_pkg::OP_NOP, 3'd0, 8'h00);
            imem[5] = rr_word(3'd1, 3'd2, 3'd3, opcode_pkg::FN_ADDU);
            imem[6] = rr_word(3'd1, 3'd2, 3'd4, opcode_pkg::FN_SUBU);
            imem[7] = imm_word(opcode_pkg::OP_ADDIU, 3'd4, 8'h80);
            imem[8] = imm_word(opcode_pkg::OP_BEQZ, 3'd0, 8'hff);
        end else begin
            imem[0] = imm_word(opcode_pkg::OP_LI, 3'd1, 8'h00);
            imem[1] = imm_word(opcode_pkg::OP_LI, 3'd2, 8'h07);
            imem[2] = imm_word(opcode_pkg::OP_BEQZ, 3'd2, 8'h02);
            imem[3] = imm_word(opcode_pkg::OP_ADDIU, 3'd2, 8'h01);
            imem[4] = imm_word(opcode_pkg::OP_BEQZ, 3'd1, 8'h02);
            imem[5] = imm_word(opcode_pkg::OP_LI, 3'd3, 8'h11);
            imem[6] = imm_word(opcode_pkg::OP_LI, 3'd4, 8'h22);
            imem[7] = rr_word(3'd2, 3'd1, 3'd5, opcode_pkg::FN_SUBU);
            imem[8] = imm_word(opcode_pkg::OP_LI, 3'd6, 8'h33);
            imem[9] = imm_word(opcode_pkg::OP_BEQZ, 3'd0, 8'hff);
        end
    endtask

    // ************************************************
    // reference model, ordered register writes
    // ************************************************

    task automatic build_expected();
        logic [`DATA_W-1:0] regs [8];
        logic [`DATA_W-1:0] w;
        logic [`DATA_W-1:0] sext;
        logic [`DATA_W-1:0] res;
        logic [2:0]         dst;
        logic               wr;
        logic [`PC_W-1:0]   pc;
        logic [`PC_W-1:0]   next_pc;
        exp_addr.delete();
        exp_data.delete();
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        pc = `RESET_PC;
        for (int step = 0; step < 200; step++) begin
            w       = imem[pc[5:0]];
            sext    = {{8{w[7]}}, w[7:0]};
            next_pc = pc + `PC_W'(1);
            dst     = w[10:8];
            wr      = 1'b1;
            res     = '0;
            case (w[15:11])
                opcode_pkg::OP_LI: res = {8'h00, w[7:0]};
                opcode_pkg::OP_ADDIU: res = regs[w[10:8]] + sext;
                opcode_pkg::OP_RR: begin
                    dst = w[4:2];
                    wr  = (w[1:0] == opcode_pkg::FN_ADDU) || (w[1:0] == opcode_pkg::FN_SUBU);
                    res = (w[1:0] == opcode_pkg::FN_ADDU) ? regs[w[10:8]] + regs[w[7:5]]
                                                          : regs[w[10:8]] - regs[w[7:5]];
                end
                opcode_pkg::OP_BEQZ: begin
                    wr = 1'b0;
                    if (regs[w[10:8]] == '0)
                        next_pc = pc + `PC_W'(1) + sext;
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                regs[dst] = res;
                exp_addr.push_back(dst);
                exp_data.push_back(res);
            end
            // a branch to itself ends the program
            if (next_pc == pc)
                break;
            pc = next_pc;
        end
    endtask

    // every writeback is matched against the head of the model list
    always @(negedge clk_50MHz) begin
        if (rst && wb_valid_o) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected writeback to register %0d after the last expected write",
                         wb_addr_o);
                errors++;
            end else begin
                assert (wb_addr_o == exp_addr[0]) else begin
                    $display("CHECK FAILED wb_addr_o expected %h got %h", exp_addr[0], wb_addr_o);
                    errors++;
                end
                assert (wb_data_o == exp_data[0]) else begin
                    $display("CHECK FAILED wb_data_o expected %h got %h", exp_data[0], wb_data_o);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    // mode 0 runs free, 1 random hold, 2 one long hold burst
    task automatic run_test(input string name, input int prog, input int mode);
        int faults_before;
        int cycles;
        faults_before = fault_total();
        @(posedge clk_50MHz);
        rst    <= 1'b0;
        hold_i <= 1'b0;
        load_program(prog);
        build_expected();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk_50MHz);
            assert (wb_valid_o == 1'b0) else begin
                $display("CHECK FAILED wb_valid_o expected %h got %h", 1'b0, wb_valid_o);
                errors++;
            end
            assert (imem_addr_o == `RESET_PC) else begin
                $display("CHECK FAILED imem_addr_o expected %h got %h", `RESET_PC, imem_addr_o);
                errors++;
            end
            if (c == 2) begin
                @(posedge clk_50MHz);
                rst <= 1'b1;
            end
        end
        cycles = 0;
        while (exp_addr.size() > 0 && cycles < RUN_LIMIT) begin
            @(posedge clk_50MHz);
            case (mode)
                1: hold_i <= ($urandom_range(2, 0) == 0);
                2: hold_i <= (cycles >= 3 && cycles < 15);
                default: hold_i <= 1'b0;
            endcase
            cycles++;
        end
        if (exp_addr.size() > 0) begin
            $display("timeout in test %s, %0d expected writebacks never arrived",
                     name, exp_addr.size());
            errors++;
            exp_addr.delete();
            exp_data.delete();
        end
        @(posedge clk_50MHz);
        hold_i <= 1'b0;
        // quiet window, a late writeback here is an extra one
        repeat (12) @(posedge clk_50MHz);
        if (fault_total() == faults_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, fault_total() - faults_before);
        end
    endtask

    initial begin
        clk_50MHz    = 1'b0;
        rst          = 1'b1;
        hold_i       = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h42d4));
        load_program(0);
        run_test("arithmetic", 0, 0);
        run_test("branch", 1, 0);
        run_test("random hold", 1, 1);
        run_test("back-pressure", 0, 2);
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (fault_total() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/isa_pkg.sv
design/opcode_pkg.sv
design/inst_stream_if.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/exec_unit.sv
design/tiny_cpu.sv
tb/cpu_assertions.sv
tb/tb_tiny_cpu.sv
